//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_bus_bridge
FILELIST   ?= files.f
OBJ_DIR    ?= obj_dir
JOBS       ?= 0
VFLAGS     ?= --binary --timing -j $(JOBS)
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- files.f
logic/bus_bridge_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/cmd_decode.sv
logic/bus_execute.sv
logic/reply_format.sv
logic/bus_bridge_top.sv
verif/tb_bus_bridge.sv

//--- logic/bus_bridge_pkg.sv
// Fixed widths and timing for the bridge with the UART baud rate set by the clock over CLKS_PER_BIT
package bus_bridge_pkg;

    typedef enum logic [1:0] {
        OP_WRITE = 2'd0,  // Bus write cycle
        OP_READ  = 2'd1,  // Bus read cycle
        OP_BAD   = 2'd2   // Rejected line, reply only
    } op_t;

    typedef enum logic [2:0] {
        EX_RESET  = 3'd0, // Peripheral held in reset
        EX_IDLE   = 3'd1, // Ready for a command
        EX_SETUP  = 3'd2, // Address and data settle
        EX_STROBE = 3'd3, // bus_wr or bus_rd high
        EX_HOLD   = 3'd4  // Strobe low, bus still driven
    } exec_state_t;

    localparam int CLKS_PER_BIT  = 8;   // Clock cycles per UART bit
    localparam int RESET_HOLD    = 100; // Peripheral reset length in cycles
    localparam int STROBE_CYCLES = 4;   // Width of bus_wr or bus_rd
    localparam int ADDR_W        = 3;
    localparam int DATA_W        = 8;

    localparam logic [7:0] ASCII_CR = 8'h0d;
    localparam logic [7:0] ASCII_LF = 8'h0a;

    // Command keywords, first character in the top byte
    localparam logic [87:0] KW_WRITE     = "pb_i_write,";
    localparam logic [79:0] KW_READ      = "pb_i_read,";
    localparam logic [3:0]  KW_WRITE_LEN = 4'd11;
    localparam logic [3:0]  KW_READ_LEN  = 4'd10;

endpackage

//--- logic/bus_bridge_top.sv
// Line based UART bridge with no flow control so the host must wait for each reply
`timescale 1ns/1ns
module bus_bridge_top (
    input  logic                              clock,
    input  logic                              arst_n,
    input  logic                              rxd,
    output logic                              txd,
    input  logic [bus_bridge_pkg::DATA_W-1:0] bus_rdata,
    output logic [bus_bridge_pkg::ADDR_W-1:0] bus_addr,
    output logic [bus_bridge_pkg::DATA_W-1:0] bus_data,
    output logic                              bus_wr,
    output logic                              bus_rd,
    output logic                              bus_reset,
    output logic                              bus_enable
);
    logic                              rx_valid;
    logic [bus_bridge_pkg::DATA_W-1:0] rx_byte;
    logic                              bus_ready;
    logic                              reply_done;
    logic                              cmd_valid;
    bus_bridge_pkg::op_t               cmd_op;
    logic [bus_bridge_pkg::ADDR_W-1:0] cmd_addr;
    logic [bus_bridge_pkg::DATA_W-1:0] cmd_data;
    logic                              done_valid;
    logic [bus_bridge_pkg::DATA_W-1:0] done_data;
    logic                              tx_valid;
    logic [bus_bridge_pkg::DATA_W-1:0] tx_byte;
    logic                              tx_busy;

    uart_rx u_uart_rx (
        .clock(clock), .arst_n(arst_n), .rxd(rxd),
        .rx_valid(rx_valid), .rx_byte(rx_byte)
    );

    cmd_decode u_cmd_decode (
        .clock(clock), .arst_n(arst_n), .rx_valid(rx_valid), .rx_byte(rx_byte),
        .bus_ready(bus_ready), .reply_done(reply_done), .cmd_valid(cmd_valid),
        .cmd_op(cmd_op), .cmd_addr(cmd_addr), .cmd_data(cmd_data)
    );

    bus_execute u_bus_execute (
        .clock(clock), .arst_n(arst_n), .cmd_valid(cmd_valid), .cmd_op(cmd_op),
        .cmd_addr(cmd_addr), .cmd_data(cmd_data), .bus_rdata(bus_rdata),
        .bus_ready(bus_ready), .done_valid(done_valid), .done_data(done_data),
        .bus_addr(bus_addr), .bus_data(bus_data), .bus_wr(bus_wr), .bus_rd(bus_rd),
        .bus_reset(bus_reset), .bus_enable(bus_enable)
    );

    reply_format u_reply_format (
        .clock(clock), .arst_n(arst_n), .cmd_valid(cmd_valid), .cmd_op(cmd_op),
        .done_valid(done_valid), .done_data(done_data), .tx_busy(tx_busy),
        .tx_valid(tx_valid), .tx_byte(tx_byte), .reply_done(reply_done)
    );

    uart_tx u_uart_tx (
        .clock(clock), .arst_n(arst_n), .tx_valid(tx_valid), .tx_byte(tx_byte),
        .txd(txd), .tx_busy(tx_busy)
    );

endmodule

//--- logic/bus_execute.sv
// Peripheral reset is released once after arst_n and a started bus cycle always runs to its end
`timescale 1ns/1ns
module bus_execute (
    input  logic                              clock,
    input  logic                              arst_n,
    input  logic                              cmd_valid,
    input  bus_bridge_pkg::op_t               cmd_op,
    input  logic [bus_bridge_pkg::ADDR_W-1:0] cmd_addr,
    input  logic [bus_bridge_pkg::DATA_W-1:0] cmd_data,
    input  logic [bus_bridge_pkg::DATA_W-1:0] bus_rdata,
    output logic                              bus_ready,
    output logic                              done_valid,
    output logic [bus_bridge_pkg::DATA_W-1:0] done_data,
    output logic [bus_bridge_pkg::ADDR_W-1:0] bus_addr,
    output logic [bus_bridge_pkg::DATA_W-1:0] bus_data,
    output logic                              bus_wr,
    output logic                              bus_rd,
    output logic                              bus_reset,
    output logic                              bus_enable
);
    bus_bridge_pkg::exec_state_t state;
    logic [7:0]                  cnt;     // Reset hold and strobe width
    logic                        is_read; // Current cycle is a read

    assign bus_ready = (state == bus_bridge_pkg::EX_IDLE);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state      <= bus_bridge_pkg::EX_RESET;
            cnt        <= '0;
            is_read    <= 1'b0;
            done_valid <= 1'b0;
            done_data  <= '0;
            bus_addr   <= '0;
            bus_data   <= '0;
            bus_wr     <= 1'b0;
            bus_rd     <= 1'b0;
            bus_reset  <= 1'b1;               // Peripheral held in reset
            bus_enable <= 1'b0;
        end else begin
            done_valid <= 1'b0;
            case (state)
                bus_bridge_pkg::EX_RESET: begin
                    if (cnt == 8'(bus_bridge_pkg::RESET_HOLD - 1)) begin
                        bus_reset  <= 1'b0;   // Release and enable board together
                        bus_enable <= 1'b1;
                        state      <= bus_bridge_pkg::EX_IDLE;
                    end else begin
                        cnt <= cnt + 8'd1;
                    end
                end
                bus_bridge_pkg::EX_IDLE: begin
                    if (cmd_valid && cmd_op != bus_bridge_pkg::OP_BAD) begin
                        bus_addr <= cmd_addr;
                        if (cmd_op == bus_bridge_pkg::OP_WRITE) begin
                            bus_data <= cmd_data; // Reads keep last data
                        end
                        is_read <= (cmd_op == bus_bridge_pkg::OP_READ);
                        state   <= bus_bridge_pkg::EX_SETUP;
                    end
                end
                bus_bridge_pkg::EX_SETUP: begin
                    bus_wr <= !is_read;
                    bus_rd <= is_read;
                    cnt    <= '0;
                    state  <= bus_bridge_pkg::EX_STROBE;
                end
                bus_bridge_pkg::EX_STROBE: begin
                    if (cnt == 8'(bus_bridge_pkg::STROBE_CYCLES - 1)) begin
                        bus_wr <= 1'b0;
                        bus_rd <= 1'b0;
                        if (is_read) begin
                            done_data <= bus_rdata; // Last strobe cycle
                        end
                        state <= bus_bridge_pkg::EX_HOLD;
                    end else begin
                        cnt <= cnt + 8'd1;
                    end
                end
                bus_bridge_pkg::EX_HOLD: begin
                    done_valid <= 1'b1;
                    state      <= bus_bridge_pkg::EX_IDLE;
                end
                default: state <= bus_bridge_pkg::EX_IDLE;
            endcase
        end
    end

endmodule

//--- logic/cmd_decode.sv
// Keywords must be exact lower case and every byte is dropped while a command is in flight
`timescale 1ns/1ns
module cmd_decode (
    input  logic                              clock,
    input  logic                              arst_n,
    input  logic                              rx_valid,
    input  logic [bus_bridge_pkg::DATA_W-1:0] rx_byte,
    input  logic                              bus_ready,
    input  logic                              reply_done,
    output logic                              cmd_valid,
    output bus_bridge_pkg::op_t               cmd_op,
    output logic [bus_bridge_pkg::ADDR_W-1:0] cmd_addr,
    output logic [bus_bridge_pkg::DATA_W-1:0] cmd_data
);
    logic [3:0]          pos;        // Characters in this line, saturates
    logic                match_wr;   // Line still fits the write form
    logic                match_rd;   // Line still fits the read form
    logic                pending;    // Line complete, bus not ready
    logic                waiting;    // Command out, reply not yet sent
    logic [4:0]          hex;        // Valid flag and nibble of rx_byte
    logic [7:0]          kw_wr_char; // Expected write keyword char at pos
    logic [7:0]          kw_rd_char; // Expected read keyword char at pos
    bus_bridge_pkg::op_t line_op;    // Verdict if CR came now

    function automatic logic [4:0] hex_decode(input logic [7:0] c);
        if (c >= "0" && c <= "9") begin
            return {1'b1, 4'(c - "0")};
        end else if (c >= "a" && c <= "f") begin
            return {1'b1, 4'(c - "a" + 8'd10)};
        end else if (c >= "A" && c <= "F") begin
            return {1'b1, 4'(c - "A" + 8'd10)};
        end
        return 5'd0;                          // Not a hex digit
    endfunction

    assign hex        = hex_decode(rx_byte);
    assign kw_wr_char = bus_bridge_pkg::KW_WRITE[8*(bus_bridge_pkg::KW_WRITE_LEN - 4'd1 - pos) +: 8];
    assign kw_rd_char = bus_bridge_pkg::KW_READ[8*(bus_bridge_pkg::KW_READ_LEN - 4'd1 - pos) +: 8];

    always_comb begin
        if (match_wr && pos == bus_bridge_pkg::KW_WRITE_LEN + 4'd3) begin      // Addr and 2 data
            line_op = bus_bridge_pkg::OP_WRITE;
        end else if (match_rd && pos == bus_bridge_pkg::KW_READ_LEN + 4'd1) begin // Addr only
            line_op = bus_bridge_pkg::OP_READ;
        end else begin
            line_op = bus_bridge_pkg::OP_BAD;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pos       <= '0;
            match_wr  <= 1'b1;
            match_rd  <= 1'b1;
            pending   <= 1'b0;
            waiting   <= 1'b0;
            cmd_valid <= 1'b0;
            cmd_op    <= bus_bridge_pkg::OP_BAD;
            cmd_addr  <= '0;
            cmd_data  <= '0;
        end else begin
            cmd_valid <= 1'b0;
            if (waiting) begin
                waiting <= !reply_done;
            end else if (pending) begin
                if (bus_ready) begin          // Held until peripheral released
                    cmd_valid <= 1'b1;
                    pending   <= 1'b0;
                    waiting   <= 1'b1;
                end
            end else if (rx_valid && rx_byte == bus_bridge_pkg::ASCII_CR) begin
                cmd_op   <= line_op;
                pos      <= '0;               // Fresh line
                match_wr <= 1'b1;
                match_rd <= 1'b1;
                cmd_valid <= bus_ready;
                waiting   <= bus_ready;
                pending   <= !bus_ready;
            end else if (rx_valid && rx_byte != bus_bridge_pkg::ASCII_LF) begin
                if (pos != 4'hf) begin
                    pos <= pos + 4'd1;
                end
                if (pos < bus_bridge_pkg::KW_WRITE_LEN) begin
                    match_wr <= match_wr && rx_byte == kw_wr_char;
                end else if (pos == bus_bridge_pkg::KW_WRITE_LEN) begin
                    match_wr <= match_wr && hex[4] && !hex[3]; // Address 0 to 7
                end else if (pos < bus_bridge_pkg::KW_WRITE_LEN + 4'd3) begin
                    match_wr <= match_wr && hex[4];
                end else begin
                    match_wr <= 1'b0;         // Too long
                end
                if (pos < bus_bridge_pkg::KW_READ_LEN) begin
                    match_rd <= match_rd && rx_byte == kw_rd_char;
                end else if (pos == bus_bridge_pkg::KW_READ_LEN) begin
                    match_rd <= match_rd && hex[4] && !hex[3];
                end else begin
                    match_rd <= 1'b0;
                end
                if (pos == bus_bridge_pkg::KW_READ_LEN || pos == bus_bridge_pkg::KW_WRITE_LEN) begin
                    cmd_addr <= hex[bus_bridge_pkg::ADDR_W-1:0]; // Write form overwrites later
                end
                if (pos == bus_bridge_pkg::KW_WRITE_LEN + 4'd1) begin
                    cmd_data[bus_bridge_pkg::DATA_W-1 -: 4] <= hex[3:0]; // High nibble
                end
                if (pos == bus_bridge_pkg::KW_WRITE_LEN + 4'd2) begin
                    cmd_data[3:0] <= hex[3:0];
                end
            end
        end
    end

endmodule

//--- logic/reply_format.sv
// Holds one reply of at most six bytes and assumes no new command arrives while it is sent
`timescale 1ns/1ns
module reply_format (
    input  logic                              clock,
    input  logic                              arst_n,
    input  logic                              cmd_valid,
    input  bus_bridge_pkg::op_t               cmd_op,
    input  logic                              done_valid,
    input  logic [bus_bridge_pkg::DATA_W-1:0] done_data,
    input  logic                              tx_busy,
    output logic                              tx_valid,
    output logic [bus_bridge_pkg::DATA_W-1:0] tx_byte,
    output logic                              reply_done
);
    logic [47:0]         msg;       // Reply text, next byte on top
    logic [2:0]          left;      // Bytes still to send
    logic                busy_q;    // tx_busy a cycle ago
    logic                last_sent; // Final byte just strobed
    bus_bridge_pkg::op_t op_q;      // Opcode of command in flight

    function automatic logic [7:0] hex_char(input logic [3:0] n);
        return (n < 4'd10) ? "0" + {4'h0, n} : "A" - 8'd10 + {4'h0, n}; // Upper case
    endfunction

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            msg        <= '0;
            left       <= '0;
            busy_q     <= 1'b0;
            last_sent  <= 1'b0;
            op_q       <= bus_bridge_pkg::OP_BAD;
            tx_valid   <= 1'b0;
            tx_byte    <= '0;
            reply_done <= 1'b0;
        end else begin
            busy_q     <= tx_busy;
            tx_valid   <= 1'b0;
            last_sent  <= 1'b0;
            reply_done <= last_sent;          // Transmitter has taken the LF
            if (cmd_valid) begin
                op_q <= cmd_op;
            end
            if (cmd_valid && cmd_op == bus_bridge_pkg::OP_BAD) begin
                msg  <= {"Fail", bus_bridge_pkg::ASCII_CR, bus_bridge_pkg::ASCII_LF};
                left <= 3'd6;
            end else if (done_valid && op_q == bus_bridge_pkg::OP_READ) begin
                msg  <= {"D", hex_char(done_data[bus_bridge_pkg::DATA_W-1 -: 4]),
                         hex_char(done_data[3:0]), bus_bridge_pkg::ASCII_CR,
                         bus_bridge_pkg::ASCII_LF, 8'h00};
                left <= 3'd5;
            end else if (done_valid) begin
                msg  <= {"Pass", bus_bridge_pkg::ASCII_CR, bus_bridge_pkg::ASCII_LF};
                left <= 3'd6;
            end else if (left != '0 && !tx_busy && !busy_q && !tx_valid) begin // Line free
                tx_byte   <= msg[47 -: bus_bridge_pkg::DATA_W];
                tx_valid  <= 1'b1;
                msg       <= msg << bus_bridge_pkg::DATA_W;
                left      <= left - 3'd1;
                last_sent <= (left == 3'd1);
            end
        end
    end

endmodule

//--- logic/uart_rx.sv
// Expects 8N1 at clock/CLKS_PER_BIT baud and silently drops frames whose stop bit is low
`timescale 1ns/1ns
module uart_rx (
    input  logic                              clock,
    input  logic                              arst_n,
    input  logic                              rxd,
    output logic                              rx_valid,
    output logic [bus_bridge_pkg::DATA_W-1:0] rx_byte
);
    typedef logic [$clog2(bus_bridge_pkg::CLKS_PER_BIT)-1:0] cnt_t;

    logic [2:0] rxd_q;   // Two sync flops plus edge history
    logic       busy;    // Frame in progress
    logic [3:0] bit_idx; // 0 start, 1 to 8 data, 9 stop, 10 tail
    cnt_t       cnt;     // Cycles to next sample point
    logic       stop_ok; // Stop bit sampled high

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            rxd_q    <= 3'b111;              // Line idles high
            busy     <= 1'b0;
            bit_idx  <= '0;
            cnt      <= '0;
            stop_ok  <= 1'b0;
            rx_valid <= 1'b0;
            rx_byte  <= '0;
        end else begin
            rxd_q    <= {rxd_q[1:0], rxd};
            rx_valid <= 1'b0;                 // Strobe by default low
            if (!busy) begin
                if (rxd_q[2] && !rxd_q[1]) begin  // Falling edge opens a frame
                    busy    <= 1'b1;
                    bit_idx <= '0;
                    cnt     <= cnt_t'(bus_bridge_pkg::CLKS_PER_BIT / 2 - 1); // To mid start bit
                end
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end else begin
                cnt     <= cnt_t'(bus_bridge_pkg::CLKS_PER_BIT - 1);
                bit_idx <= bit_idx + 4'd1;
                case (bit_idx)
                    4'd0: busy <= !rxd_q[1];      // Start bit gone high means glitch
                    4'd9: begin
                        stop_ok <= rxd_q[1];
                        cnt     <= cnt_t'(bus_bridge_pkg::CLKS_PER_BIT / 2 - 1); // Half bit on
                    end
                    4'd10: begin
                        busy     <= 1'b0;
                        rx_valid <= stop_ok;      // No strobe on framing error
                    end
                    default: rx_byte <= {rxd_q[1], rx_byte[bus_bridge_pkg::DATA_W-1:1]}; // LSB first
                endcase
            end
        end
    end

endmodule

//--- logic/uart_tx.sv
// Sends 8N1 frames of 10*CLKS_PER_BIT cycles and ignores any strobe that arrives while busy
`timescale 1ns/1ns
module uart_tx (
    input  logic                              clock,
    input  logic                              arst_n,
    input  logic                              tx_valid,
    input  logic [bus_bridge_pkg::DATA_W-1:0] tx_byte,
    output logic                              txd,
    output logic                              tx_busy
);
    typedef logic [$clog2(bus_bridge_pkg::CLKS_PER_BIT)-1:0] cnt_t;

    logic [bus_bridge_pkg::DATA_W+1:0] frame;     // Stop, data and start bits, LSB out first
    logic [3:0]                        bits_left; // Bit periods after the current one
    cnt_t                              cnt;       // Cycles left in current bit

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            frame     <= '1;                  // Idle line high
            tx_busy   <= 1'b0;
            bits_left <= '0;
            cnt       <= '0;
        end else if (!tx_busy) begin
            if (tx_valid) begin
                frame     <= {1'b1, tx_byte, 1'b0};
                tx_busy   <= 1'b1;
                bits_left <= 4'd9;
                cnt       <= cnt_t'(bus_bridge_pkg::CLKS_PER_BIT - 1);
            end
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end else if (bits_left == '0) begin
            tx_busy <= 1'b0;                  // End of stop bit
        end else begin
            frame     <= {1'b1, frame[bus_bridge_pkg::DATA_W+1:1]}; // Ones fill behind
            bits_left <= bits_left - 4'd1;
            cnt       <= cnt_t'(bus_bridge_pkg::CLKS_PER_BIT - 1);
        end
    end

    assign txd = frame[0];                    // Registered, glitch free

endmodule

//--- verif/tb_bus_bridge.sv
// Runs 240 command lines from a fixed seed and assumes each reply is complete before the next line
`timescale 1ns/1ns
module tb_bus_bridge;
    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DELAY = 2;                    // ns after the rising edge
    localparam int BIT_CLKS    = bus_bridge_pkg::CLKS_PER_BIT;
    localparam int N_WRITES    = 16;
    localparam int N_READS     = 16;
    localparam int N_BAD       = 8;                    // 4 flaws on both line forms
    localparam int N_MIXED     = 200;
    localparam int N_CMDS      = N_WRITES + N_READS + N_BAD + N_MIXED;
    localparam int WATCHDOG_NS = N_CMDS * 24 * 10 * BIT_CLKS * CLK_PERIOD
                               + bus_bridge_pkg::RESET_HOLD * CLK_PERIOD;

    logic       clock;
    logic       arst_n;
    logic       rxd;
    logic       txd;
    logic [7:0] bus_rdata = 8'h00;
    logic [2:0] bus_addr;
    logic [7:0] bus_data;
    logic       bus_wr;
    logic       bus_rd;
    logic       bus_reset;
    logic       bus_enable;

    logic [31:0] lcg_state = 32'h36b0;
    logic [7:0]  periph_mem [0:7];                    // Peripheral registers
    logic [7:0]  model_mem [0:7];                     // Expected register contents
    logic [7:0]  reply_q [$];                         // Bytes decoded from txd
    int          rd_idx = 0;                          // Next reply byte to check
    int          wr_pulses = 0;
    int          rd_pulses = 0;
    int          last_width = 0;
    logic [2:0]  last_addr = '0;
    logic [7:0]  last_data = '0;
    logic        last_rd = 1'b0;

    bus_bridge_top DUT (
        .clock(clock), .arst_n(arst_n), .rxd(rxd), .txd(txd), .bus_rdata(bus_rdata),
        .bus_addr(bus_addr), .bus_data(bus_data), .bus_wr(bus_wr), .bus_rd(bus_rd),
        .bus_reset(bus_reset), .bus_enable(bus_enable)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("ERROR: time %0t: %s: got 0x%0h, expected 0x%0h", $time, what, got, exp);
            $display("** FAIL **");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic int rand_below(input int n);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'(lcg_state[30:16]) % n;           // Upper bits have the longer period
    endfunction

    function automatic bit coin();
        return rand_below(2) == 1;
    endfunction

    function automatic logic [7:0] fill_value(input logic [2:0] a);
        return 8'h3c ^ (8'(a) * 8'd29);
    endfunction

    function automatic logic [7:0] digit_char(input logic [3:0] n, input bit lower);
        if (n < 4'd10) begin
            return "0" + 8'(n);
        end
        return (lower ? "a" : "A") + 8'(n) - 8'd10;
    endfunction

    function automatic int hex_val(input logic [7:0] c);
        if (c >= "0" && c <= "9") begin
            return int'(c) - 48;
        end else if (c >= "a" && c <= "f") begin
            return int'(c) - 87;
        end else if (c >= "A" && c <= "F") begin
            return int'(c) - 55;
        end
        return -1;                                   // Not a hex digit
    endfunction

    // Exact lower-case keyword, address 0 to 7, hex of either case and exact length
    function automatic bus_bridge_pkg::op_t parse_line(input string s, output logic [2:0] a,
                                                       output logic [7:0] d);
        int v0;
        int v1;
        int v2;
        a = '0;
        d = '0;
        if (s.len() == 14 && s.substr(0, 10) == "pb_i_write,") begin
            v0 = hex_val(s[11]);
            v1 = hex_val(s[12]);
            v2 = hex_val(s[13]);
            if (v0 >= 0 && v0 < 8 && v1 >= 0 && v2 >= 0) begin
                a = 3'(v0);
                d = 8'(v1 * 16 + v2);
                return bus_bridge_pkg::OP_WRITE;
            end
        end else if (s.len() == 11 && s.substr(0, 9) == "pb_i_read,") begin
            v0 = hex_val(s[10]);
            if (v0 >= 0 && v0 < 8) begin
                a = 3'(v0);
                return bus_bridge_pkg::OP_READ;
            end
        end
        return bus_bridge_pkg::OP_BAD;
    endfunction

    // Flaw -1 none, 0 keyword char, 1 non-hex digit, 2 address 8 to F, 3 length
    function automatic string make_line(input bit is_read, input int flaw);
        string      s;
        logic [3:0] a;
        logic [7:0] d;
        int         pos;
        a = 4'(rand_below(8));
        d = 8'(rand_below(256));
        if (flaw == 2) begin
            a = 4'(8 + rand_below(8));
        end
        if (is_read) begin
            s = $sformatf("pb_i_read,%c", digit_char(a, coin()));
        end else begin
            s = $sformatf("pb_i_write,%c%c%c", digit_char(a, coin()),
                          digit_char(d[7:4], coin()), digit_char(d[3:0], coin()));
        end
        case (flaw)
            0: begin
                pos = rand_below(10);                // Shared keyword span
                s.putc(pos, s[pos] ^ 8'h20);
            end
            1: begin
                pos = s.len() - 1 - rand_below(is_read ? 1 : 3);
                s.putc(pos, 8'(103 + rand_below(20))); // g to z
            end
            3: begin
                if (coin()) begin
                    s = s.substr(0, s.len() - 2);    // One short
                end else begin
                    s = $sformatf("%s%c", s, digit_char(4'(rand_below(16)), coin()));
                end
            end
            default: ;
        endcase
        return s;
    endfunction

    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        int         k;
        frame = {1'b1, b, 1'b0};                     // Stop, data, start
        for (k = 0; k < 10; k++) begin
            @(posedge clock);
            #DRIVE_DELAY;
            rxd = frame[k];
            repeat (BIT_CLKS - 1) @(posedge clock);
        end
        repeat (BIT_CLKS / 2) @(posedge clock);     // Idle gap lets rx rearm
    endtask

    task automatic expect_reply(input string text);
        string full;
        int    k;
        full = $sformatf("%s%c%c", text, bus_bridge_pkg::ASCII_CR, bus_bridge_pkg::ASCII_LF);
        while (reply_q.size() < rd_idx + full.len()) begin
            @(negedge clock);
        end
        for (k = 0; k < full.len(); k++) begin
            compare(32'(reply_q[rd_idx]), 32'(full[k]),
                    $sformatf("reply byte %0d of %s", k, text));
            rd_idx++;
        end
    endtask

    task automatic run_cmd(input string line, input bit with_lf);
        bus_bridge_pkg::op_t op;
        logic [2:0]          a;
        logic [7:0]          d;
        int                  wr0;
        int                  rd0;
        int                  k;
        op  = parse_line(line, a, d);
        wr0 = wr_pulses;
        rd0 = rd_pulses;
        for (k = 0; k < line.len(); k++) begin
            send_byte(line[k]);
        end
        send_byte(bus_bridge_pkg::ASCII_CR);
        if (op == bus_bridge_pkg::OP_WRITE) begin
            model_mem[a] = d;
            expect_reply("Pass");
        end else if (op == bus_bridge_pkg::OP_READ) begin
            expect_reply($sformatf("D%c%c", digit_char(model_mem[a][7:4], 1'b0),
                                   digit_char(model_mem[a][3:0], 1'b0)));
        end else begin
            expect_reply("Fail");
        end
        compare(32'(wr_pulses), 32'(wr0 + (op == bus_bridge_pkg::OP_WRITE)),
                $sformatf("bus_wr pulses for %s", line));
        compare(32'(rd_pulses), 32'(rd0 + (op == bus_bridge_pkg::OP_READ)),
                $sformatf("bus_rd pulses for %s", line));
        if (op != bus_bridge_pkg::OP_BAD) begin
            compare(32'(last_width), 32'(bus_bridge_pkg::STROBE_CYCLES), "strobe width");
            compare(32'(last_addr), 32'(a), $sformatf("bus_addr for %s", line));
            if (op == bus_bridge_pkg::OP_WRITE) begin
                compare(32'(last_data), 32'(d), $sformatf("bus_data for %s", line));
            end
        end
        if (with_lf) begin
            send_byte(bus_bridge_pkg::ASCII_LF);   // Reaches the decoder when idle
        end
    endtask

    // Peripheral answers reads a little after each edge
    always @(posedge clock) begin
        #DRIVE_DELAY;
        bus_rdata = bus_rd ? periph_mem[bus_addr] : 8'h00;
    end

    initial begin : bus_monitor
        int i;
        int len;
        len = 0;
        for (i = 0; i < 8; i++) begin
            periph_mem[3'(i)] = fill_value(3'(i));
        end
        forever begin
            @(negedge clock);
            compare(32'(bus_wr & bus_rd), 32'd0, "bus_wr and bus_rd together");
            if (bus_wr || bus_rd) begin
                if (len == 0) begin                  // First strobe cycle
                    last_addr = bus_addr;
                    last_data = bus_data;
                    last_rd   = bus_rd;
                    if (bus_wr) begin
                        periph_mem[bus_addr] = bus_data;
                    end
                end
                compare(32'(bus_addr), 32'(last_addr), "bus_addr stable in strobe");
                len++;
            end else if (len != 0) begin
                last_width = len;
                if (last_rd) begin
                    rd_pulses++;
                end else begin
                    wr_pulses++;
                end
                len = 0;
            end
        end
    end

    initial begin : tx_monitor
        logic [7:0] b;
        int         k;
        forever begin
            @(negedge clock);
            if (arst_n === 1'b1 && txd === 1'b0) begin
                repeat (BIT_CLKS / 2) @(negedge clock); // Middle of start bit
                for (k = 0; k < 8; k++) begin
                    repeat (BIT_CLKS) @(negedge clock);
                    b[3'(k)] = txd;                  // LSB first
                end
                repeat (BIT_CLKS) @(negedge clock);
                compare(32'(txd), 32'd1, "txd stop bit");
                reply_q.push_back(b);
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns: a reply or bus cycle never finished", WATCHDOG_NS);
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

    initial begin : main
        int    i;
        int    kind;
        string line;
        arst_n = 1'b0;
        rxd    = 1'b1;                               // Idle line
        for (i = 0; i < 8; i++) begin
            model_mem[3'(i)] = fill_value(3'(i));
        end
        repeat (8) @(posedge clock);
        #DRIVE_DELAY;
        arst_n = 1'b1;
        for (i = 1; i <= bus_bridge_pkg::RESET_HOLD; i++) begin
            @(posedge clock);
            @(negedge clock);
            compare(32'(bus_reset), 32'(i < bus_bridge_pkg::RESET_HOLD), "bus_reset in hold");
            compare(32'(bus_enable), 32'(i == bus_bridge_pkg::RESET_HOLD), "bus_enable in hold");
            compare(32'(bus_wr | bus_rd), 32'd0, "bus strobe in hold");
        end
        for (i = 0; i < N_WRITES; i++) begin
            run_cmd(make_line(1'b0, -1), 1'b0);
        end
        for (i = 0; i < N_READS; i++) begin
            run_cmd(make_line(1'b1, -1), 1'b1);
        end
        for (i = 0; i < N_BAD; i++) begin
            run_cmd(make_line(i[0], i / 2), coin()); // Each flaw on both forms
        end
        for (i = 0; i < N_MIXED; i++) begin
            kind = rand_below(10);
            if (kind < 4) begin
                line = make_line(1'b0, -1);
            end else if (kind < 7) begin
                line = make_line(1'b1, -1);
            end else begin
                line = make_line(coin(), rand_below(4));
            end
            run_cmd(line, coin());
        end
        repeat (20 * BIT_CLKS) @(posedge clock);    // Catch any stray reply byte
        compare(32'(reply_q.size()), 32'(rd_idx), "reply bytes beyond the last reply");
        $display("** PASS **");
        $finish;
    end

endmodule
